//--- hdl/cache_geom_pkg.sv
`default_nettype none

package cache_geom_pkg;

   // cpu side widths
   localparam int ADDR_WIDTH = 32;
   localparam int WORD_WIDTH = 32;
   localparam int WORD_BYTES_LOG = 2;

   // default geometry, overridden from the top level
   localparam int DEF_WORDS_PER_LINE = 4;
   localparam int DEF_NUM_SETS = 16;

   // two ways, lru is a single bit per set
   localparam int NUM_WAYS = 2;

   // byte offset inside a line
   function automatic int offset_bits(int words_per_line);
      return $clog2(words_per_line) + WORD_BYTES_LOG;
   endfunction

   function automatic int index_bits(int num_sets);
      return $clog2(num_sets);
   endfunction

   // whatever is left above index and offset
   function automatic int tag_bits(int words_per_line, int num_sets);
      return ADDR_WIDTH - offset_bits(words_per_line) - index_bits(num_sets);
   endfunction

endpackage

`default_nettype wire

//--- hdl/cache_ctrl_pkg.sv
`default_nettype none

package cache_ctrl_pkg;

   // controller states
   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,
      REFILL,
      RESPOND,
      INVAL
   } ctrl_state_t;

   // outcome of the tag compare for the held address
   typedef struct packed {
      logic hit;
      // way that matched, only meaningful with hit
      logic hit_way;
      // least recently used way of the set
      logic victim_way;
   } lookup_res_t;

endpackage

`default_nettype wire

//--- hdl/refill_if.sv
`default_nettype none

interface refill_if;

   // memory beat, straight from the memory port
   logic beat_valid;
   logic [cache_geom_pkg::WORD_WIDTH-1:0] beat_data;

   // final beat of the line
   logic last;

   // refill window, beats outside it are ignored
   logic active;

   modport counter (input beat_valid, input active, output last);
   modport buffer (input beat_valid, input beat_data, input active);
   modport ctrl (input last, output active);

endinterface

`default_nettype wire

//--- hdl/way_ram.sv
`default_nettype none

module way_ram #(
   parameter type entry_t = logic [31:0],
   parameter int DEPTH = 16,
   localparam int AW = $clog2(DEPTH)
) (
   input logic clk,

   // read port, data one cycle later
   input logic [AW-1:0] raddr,

   // write port
   input logic we,
   input logic [AW-1:0] waddr,
   input entry_t wdata,

   output entry_t rdata
);

   entry_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[waddr] <= wdata;
      end
   end

   // read before write on a same-address collision
   always_ff @(posedge clk) begin
      rdata <= mem[raddr];
   end

endmodule

`default_nettype wire

//--- hdl/cache_lookup.sv
`default_nettype none

module cache_lookup #(
   parameter int WORDS_PER_LINE = cache_geom_pkg::DEF_WORDS_PER_LINE,
   parameter int NUM_SETS = cache_geom_pkg::DEF_NUM_SETS,
   localparam int LINE_W = cache_geom_pkg::WORD_WIDTH * WORDS_PER_LINE
) (
   input logic clk,
   input logic reset,
   input logic [cache_geom_pkg::ADDR_WIDTH-1:0] lookup_addr,
   input logic [cache_geom_pkg::ADDR_WIDTH-1:0] hold_addr,
   input logic fill_we,
   input logic [LINE_W-1:0] fill_line,
   input logic inv_we,
   input logic inv_way,
   input logic touch,
   output cache_ctrl_pkg::lookup_res_t result,
   output logic [cache_geom_pkg::NUM_WAYS-1:0][LINE_W-1:0] way_lines
);
   import cache_geom_pkg::*;

   localparam int OFFSET_W = offset_bits(WORDS_PER_LINE);
   localparam int INDEX_W = index_bits(NUM_SETS);
   localparam int TAG_W = tag_bits(WORDS_PER_LINE, NUM_SETS);

   logic [INDEX_W-1:0] rd_idx;
   logic [INDEX_W-1:0] hold_idx;
   logic [TAG_W-1:0] hold_tag;
   logic [NUM_WAYS-1:0][TAG_W-1:0] tag_rd;
   logic [NUM_WAYS-1:0] hit_vec;
   logic [NUM_WAYS-1:0] way_we;
   logic [NUM_SETS-1:0][NUM_WAYS-1:0] valid_q;
   logic [NUM_SETS-1:0] lru_q;
   logic used_way;

   assign rd_idx = lookup_addr[OFFSET_W +: INDEX_W];
   assign hold_idx = hold_addr[OFFSET_W +: INDEX_W];
   assign hold_tag = hold_addr[ADDR_WIDTH-1 -: TAG_W];

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      // only the victim takes the refilled line
      assign way_we[w] = fill_we && (lru_q[hold_idx] == 1'(w));

      way_ram #(.entry_t(logic [TAG_W-1:0]), .DEPTH(NUM_SETS)) tag_ram_inst (
         .clk,
         .raddr(rd_idx),
         .we(way_we[w]),
         .waddr(hold_idx),
         .wdata(hold_tag),
         .rdata(tag_rd[w])
      );

      way_ram #(.entry_t(logic [LINE_W-1:0]), .DEPTH(NUM_SETS)) line_ram_inst (
         .clk,
         .raddr(rd_idx),
         .we(way_we[w]),
         .waddr(hold_idx),
         .wdata(fill_line),
         .rdata(way_lines[w])
      );

      assign hit_vec[w] = valid_q[hold_idx][w] && (tag_rd[w] == hold_tag);
   end

   assign result = '{hit: |hit_vec, hit_way: hit_vec[1], victim_way: lru_q[hold_idx]};

   // the victim served the response unless the other way hits
   assign used_way = hit_vec[!result.victim_way] ? !result.victim_way : result.victim_way;

   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= '0;
         lru_q <= '0;
      end else begin
         if (fill_we) begin
            valid_q[hold_idx][result.victim_way] <= 1'b1;
         end
         if (inv_we) begin
            valid_q[hold_idx][inv_way] <= 1'b0;
         end
         if (touch) begin
            lru_q[hold_idx] <= ~used_way;
         end
      end
   end

   // a line is never resident in both ways of a set
   a_single_hit: assert property (@(posedge clk) disable iff (reset) $onehot0(hit_vec));

endmodule

`default_nettype wire

//--- hdl/refill_counter.sv
`default_nettype none

module refill_counter #(
   parameter int WORDS_PER_LINE = cache_geom_pkg::DEF_WORDS_PER_LINE,
   localparam int CNT_W = $clog2(WORDS_PER_LINE + 1)
) (
   input logic clk,
   input logic reset,
   refill_if.counter refill
);

   logic [CNT_W-1:0] beat_cnt;

   // cleared whenever no refill is open
   always_ff @(posedge clk) begin
      if (reset || !refill.active) begin
         beat_cnt <= '0;
      end else if (refill.beat_valid) begin
         beat_cnt <= beat_cnt + 1'b1;
      end
   end

   // flags the beat that completes the line
   assign refill.last = refill.active && refill.beat_valid &&
                        (beat_cnt == CNT_W'(WORDS_PER_LINE - 1));

   // controller must close the window right after the last beat
   a_cnt_bound: assert property (
      @(posedge clk) disable iff (reset) beat_cnt <= CNT_W'(WORDS_PER_LINE)
   );

endmodule

`default_nettype wire

//--- hdl/line_buffer.sv
`default_nettype none

module line_buffer #(
   parameter int WORDS_PER_LINE = cache_geom_pkg::DEF_WORDS_PER_LINE,
   localparam int LINE_W = cache_geom_pkg::WORD_WIDTH * WORDS_PER_LINE,
   localparam int SEL_W = $clog2(WORDS_PER_LINE)
) (
   input logic clk,
   refill_if.buffer refill,
   input logic [SEL_W-1:0] word_sel,
   input logic [LINE_W-1:0] hit_line,
   input logic from_refill,
   output logic [LINE_W-1:0] line,
   output logic [cache_geom_pkg::WORD_WIDTH-1:0] word
);
   import cache_geom_pkg::*;

   logic [LINE_W-1:0] line_q;
   logic [LINE_W-1:0] src_line;

   // new beat enters at the top, older words move down
   // after a full line word 0 sits in the low bits
   assign line = {refill.beat_data, line_q[LINE_W-1:WORD_WIDTH]};

   always_ff @(posedge clk) begin
      if (refill.active && refill.beat_valid) begin
         line_q <= line;
      end
   end

   // refilled line after a miss, ram output on a hit
   assign src_line = from_refill ? line_q : hit_line;

   assign word = src_line[word_sel * WORD_WIDTH +: WORD_WIDTH];

endmodule

`default_nettype wire

//--- hdl/icache_fsm.sv
`default_nettype none

module icache_fsm (
   input logic clk,
   input logic reset,
   input logic req_valid,
   input logic inv_valid,
   input logic rdata_ready,
   input logic mem_rvalid,
   input cache_ctrl_pkg::lookup_res_t result,
   refill_if.ctrl refill,
   output logic req_ready,
   output logic rdata_valid,
   output logic mem_req,
   output logic inv_done,
   output logic accept,
   output logic fill_we,
   output logic inv_we,
   output logic touch,
   output logic from_refill
);
   import cache_ctrl_pkg::*;

   ctrl_state_t state_q;
   ctrl_state_t state_d;
   logic req_open;
   logic miss;

   assign miss = (state_q == LOOKUP) && !result.hit;

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            // invalidate wins over a read
            if (inv_valid) begin
               state_d = INVAL;
            end else if (req_valid) begin
               state_d = LOOKUP;
            end
         end
         LOOKUP: begin
            if (!result.hit) begin
               state_d = REFILL;
            end else if (rdata_ready) begin
               state_d = IDLE;
            end
         end
         REFILL: begin
            if (refill.last) begin
               state_d = RESPOND;
            end
         end
         RESPOND: begin
            if (rdata_ready) begin
               state_d = IDLE;
            end
         end
         default: begin
            state_d = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= IDLE;
         req_open <= 1'b0;
      end else begin
         state_q <= state_d;
         // line request stays up until memory starts answering
         if (miss) begin
            req_open <= 1'b1;
         end else if (mem_rvalid) begin
            req_open <= 1'b0;
         end
      end
   end

   assign req_ready = (state_q == IDLE) && !inv_valid;
   assign accept = (state_q == IDLE) && (inv_valid || req_valid);
   assign mem_req = miss || req_open;
   assign refill.active = (state_q == REFILL);
   assign fill_we = (state_q == REFILL) && refill.last;
   assign inv_we = (state_q == INVAL);
   assign inv_done = (state_q == INVAL);
   assign from_refill = (state_q == RESPOND);
   assign rdata_valid = ((state_q == LOOKUP) && result.hit) || (state_q == RESPOND);
   assign touch = rdata_valid && rdata_ready;

   // a stalled response is never withdrawn
   a_valid_hold: assert property (
      @(posedge clk) disable iff (reset) rdata_valid && !rdata_ready |=> rdata_valid
   );

endmodule

`default_nettype wire

//--- hdl/icache_top.sv
`default_nettype none

module icache_top #(
   parameter int WORDS_PER_LINE = cache_geom_pkg::DEF_WORDS_PER_LINE,
   parameter int NUM_SETS = cache_geom_pkg::DEF_NUM_SETS
) (
   input logic clk,
   input logic reset,
   input logic req_valid,
   input logic [cache_geom_pkg::ADDR_WIDTH-1:0] req_addr,
   output logic req_ready,
   output logic [cache_geom_pkg::WORD_WIDTH-1:0] rdata,
   output logic rdata_valid,
   input logic rdata_ready,
   input logic inv_valid,
   input logic [cache_geom_pkg::ADDR_WIDTH-1:0] inv_addr,
   output logic inv_done,
   output logic mem_req,
   output logic [cache_geom_pkg::ADDR_WIDTH-1:0] mem_addr,
   input logic [cache_geom_pkg::WORD_WIDTH-1:0] mem_rdata,
   input logic mem_rvalid
);
   import cache_geom_pkg::*;
   import cache_ctrl_pkg::*;

   localparam int OFFSET_W = offset_bits(WORDS_PER_LINE);
   localparam int LINE_W = WORD_WIDTH * WORDS_PER_LINE;

   logic [ADDR_WIDTH-1:0] next_addr;
   logic [ADDR_WIDTH-1:0] hold_addr;
   logic [ADDR_WIDTH-1:0] lookup_addr;
   lookup_res_t result;
   logic accept;
   logic fill_we;
   logic inv_we;
   logic touch;
   logic from_refill;
   logic [NUM_WAYS-1:0][LINE_W-1:0] way_lines;
   logic [LINE_W-1:0] fill_line;

   refill_if refill ();

   assign refill.beat_valid = mem_rvalid;
   assign refill.beat_data = mem_rdata;

   // address of whichever operation is taken this cycle
   assign next_addr = inv_valid ? inv_addr : req_addr;

   always_ff @(posedge clk) begin
      if (reset) begin
         hold_addr <= '0;
      end else if (accept) begin
         hold_addr <= next_addr;
      end
   end

   // rams see the live address on acceptance, the held one while busy
   assign lookup_addr = accept ? next_addr : hold_addr;

   assign mem_addr = {hold_addr[ADDR_WIDTH-1:OFFSET_W], {OFFSET_W{1'b0}}};

   icache_fsm icache_fsm_inst (
      .clk,
      .reset,
      .req_valid,
      .inv_valid,
      .rdata_ready,
      .mem_rvalid,
      .result,
      .refill(refill.ctrl),
      .req_ready,
      .rdata_valid,
      .mem_req,
      .inv_done,
      .accept,
      .fill_we,
      .inv_we,
      .touch,
      .from_refill
   );

   refill_counter #(.WORDS_PER_LINE(WORDS_PER_LINE)) refill_counter_inst (
      .clk,
      .reset,
      .refill(refill.counter)
   );

   line_buffer #(.WORDS_PER_LINE(WORDS_PER_LINE)) line_buffer_inst (
      .clk,
      .refill(refill.buffer),
      .word_sel(hold_addr[OFFSET_W-1:WORD_BYTES_LOG]),
      .hit_line(way_lines[result.hit_way]),
      .from_refill,
      .line(fill_line),
      .word(rdata)
   );

   // invalidate picks its way from the lowest address bit
   cache_lookup #(.WORDS_PER_LINE(WORDS_PER_LINE), .NUM_SETS(NUM_SETS)) cache_lookup_inst (
      .clk,
      .reset,
      .lookup_addr,
      .hold_addr,
      .fill_we,
      .fill_line,
      .inv_we,
      .inv_way(hold_addr[0]),
      .touch,
      .result,
      .way_lines
   );

endmodule

`default_nettype wire

//--- sim/mem_model.sv
`default_nettype none

module mem_model #(
   parameter int WORDS_PER_LINE = 4,
   parameter int MAX_GAP = 3
) (
   input logic clk,
   input logic reset,
   input logic mem_req,
   input logic [31:0] mem_addr,
   output logic [31:0] mem_rdata,
   output logic mem_rvalid
);
   timeunit 1ns;
   timeprecision 1ps;

   logic [31:0] line_base;
   int gap;

   // word address xor a fixed pattern
   function automatic logic [31:0] word_at(input logic [31:0] byte_addr);
      return {2'b00, byte_addr[31:2]} ^ 32'hA5A5_0000;
   endfunction

   initial begin
      mem_rvalid = 1'b0;
      mem_rdata = '0;
      line_base = '0;
      gap = 0;
      forever begin
         @(posedge clk);
         if (!reset && mem_req) begin
            line_base = mem_addr;
            // one beat per word, random idle cycles before each
            for (int i = 0; i < WORDS_PER_LINE; i++) begin
               gap = $urandom_range(0, MAX_GAP);
               @(negedge clk);
               mem_rvalid = 1'b0;
               repeat (gap) @(negedge clk);
               mem_rvalid = 1'b1;
               mem_rdata = word_at(line_base + 32'(i * 4));
            end
            @(negedge clk);
            mem_rvalid = 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

//--- sim/icache_tb.sv
`default_nettype none

module icache_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int WORDS_PER_LINE = 4;
   localparam int NUM_SETS = 16;
   localparam int TIMEOUT = 200;
   localparam int NUM_RANDOM = 24;
   localparam logic [31:0] LINE_MASK = ~32'(WORDS_PER_LINE * 4 - 1);

   typedef enum {OP_READ, OP_INVAL} op_t;

   typedef struct {
      string name;
      op_t op;
      logic [31:0] addr;
      bit miss;
   } test_t;

   logic clk;
   logic reset;
   logic req_valid;
   logic [31:0] req_addr;
   logic req_ready;
   logic [31:0] rdata;
   logic rdata_valid;
   logic rdata_ready;
   logic inv_valid;
   logic [31:0] inv_addr;
   logic inv_done;
   logic mem_req;
   logic [31:0] mem_addr;
   logic [31:0] mem_rdata;
   logic mem_rvalid;

   test_t tests[$];
   int test_errors;
   int pass_count;
   int fail_count;
   bit timed_out;
   int mem_req_rises;
   logic mem_req_q = 1'b0;
   logic [31:0] req_line_addr;

   icache_top #(.WORDS_PER_LINE(WORDS_PER_LINE), .NUM_SETS(NUM_SETS)) icache_top_inst (
      .clk,
      .reset,
      .req_valid,
      .req_addr,
      .req_ready,
      .rdata,
      .rdata_valid,
      .rdata_ready,
      .inv_valid,
      .inv_addr,
      .inv_done,
      .mem_req,
      .mem_addr,
      .mem_rdata,
      .mem_rvalid
   );

   mem_model #(.WORDS_PER_LINE(WORDS_PER_LINE), .MAX_GAP(3)) mem_model_inst (
      .clk,
      .reset,
      .mem_req,
      .mem_addr,
      .mem_rdata,
      .mem_rvalid
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // line requests seen by memory, sampled on the rising edge
   always @(posedge clk) begin
      if (mem_req && !mem_req_q) begin
         mem_req_rises = mem_req_rises + 1;
         req_line_addr = mem_addr;
      end
      mem_req_q = mem_req;
   end

   function automatic logic [31:0] expected_word(input logic [31:0] addr);
      return {2'b00, addr[31:2]} ^ 32'hA5A5_0000;
   endfunction

   task automatic add_test(input string name, input op_t op, input logic [31:0] addr,
                           input bit miss);
      test_t t;
      t.name = name;
      t.op = op;
      t.addr = addr;
      t.miss = miss;
      tests.push_back(t);
   endtask

   task automatic check_word(input string name, input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
      assert (actual === expected) else begin
         $display("error: %s %s expected %h actual %h", name, what, expected, actual);
         test_errors++;
      end
   endtask

   task automatic check_count(input string name, input string what, input int expected,
                              input int actual);
      assert (actual == expected) else begin
         $display("error: %s %s expected %0d actual %0d", name, what, expected, actual);
         test_errors++;
      end
   endtask

   task automatic report_timeout(input string name, input string what);
      $display("%s: gave up after %0d cycles waiting for %s", name, TIMEOUT, what);
      timed_out = 1'b1;
   endtask

   task automatic report_test(input string name);
      if (test_errors == 0 && !timed_out) begin
         $display("test %s ok", name);
         pass_count++;
      end else begin
         $display("test %s failed", name);
         fail_count++;
      end
   endtask

   task automatic run_read(input string name, input logic [31:0] addr, input int exp_miss);
      logic [31:0] first_data;
      int cycles;
      int stall;
      mem_req_rises = 0;
      req_valid = 1'b1;
      req_addr = addr;
      cycles = 0;
      while (!req_ready && !timed_out) begin
         @(negedge clk);
         cycles++;
         if (cycles >= TIMEOUT) begin
            report_timeout(name, "req_ready");
         end
      end
      if (timed_out) return;
      // accepted on the rising edge in between
      @(negedge clk);
      req_valid = 1'b0;
      cycles = 1;
      while (!rdata_valid && !timed_out) begin
         @(negedge clk);
         cycles++;
         if (cycles >= TIMEOUT) begin
            report_timeout(name, "rdata_valid");
         end
      end
      if (timed_out) return;
      if (exp_miss == 0) begin
         check_count(name, "hit latency", 1, cycles);
      end
      first_data = rdata;
      check_word(name, "rdata", expected_word(addr), rdata);
      stall = $urandom_range(0, 3);
      repeat (stall) begin
         @(negedge clk);
         assert (rdata_valid && rdata === first_data) else begin
            $display("%s: response dropped or changed while rdata_ready was low", name);
            test_errors++;
         end
      end
      rdata_ready = 1'b1;
      @(negedge clk);
      rdata_ready = 1'b0;
      assert (!rdata_valid) else begin
         $display("%s: rdata_valid still high after the transfer", name);
         test_errors++;
      end
      if (exp_miss >= 0) begin
         check_count(name, "mem_req rises", exp_miss, mem_req_rises);
      end
      if (mem_req_rises > 0) begin
         check_word(name, "mem_addr", addr & LINE_MASK, req_line_addr);
      end
   endtask

   task automatic run_inval(input string name, input logic [31:0] addr);
      int cycles;
      mem_req_rises = 0;
      cycles = 0;
      while (!req_ready && !timed_out) begin
         @(negedge clk);
         cycles++;
         if (cycles >= TIMEOUT) begin
            report_timeout(name, "idle controller");
         end
      end
      if (timed_out) return;
      inv_valid = 1'b1;
      inv_addr = addr;
      @(negedge clk);
      inv_valid = 1'b0;
      cycles = 1;
      while (!inv_done && !timed_out) begin
         @(negedge clk);
         cycles++;
         if (cycles >= TIMEOUT) begin
            report_timeout(name, "inv_done");
         end
      end
      if (timed_out) return;
      check_count(name, "inv_done latency", 1, cycles);
      @(negedge clk);
      assert (!inv_done) else begin
         $display("%s: inv_done stayed high for more than one cycle", name);
         test_errors++;
      end
      check_count(name, "mem_req rises", 0, mem_req_rises);
   endtask

   initial begin
      void'($urandom(32'h6ece9239));
      reset = 1'b1;
      req_valid = 1'b0;
      req_addr = '0;
      rdata_ready = 1'b0;
      inv_valid = 1'b0;
      inv_addr = '0;
      test_errors = 0;
      pass_count = 0;
      fail_count = 0;
      timed_out = 1'b0;
      mem_req_rises = 0;
      req_line_addr = '0;

      // set 3 for replacement, set 5 for invalidate
      add_test("cold_read", OP_READ, 32'h0000_1038, 1'b1);
      add_test("same_line_lo", OP_READ, 32'h0000_1030, 1'b0);
      add_test("same_line_hi", OP_READ, 32'h0000_103C, 1'b0);
      add_test("read_b", OP_READ, 32'h0000_2034, 1'b1);
      add_test("reread_a", OP_READ, 32'h0000_1034, 1'b0);
      add_test("read_c", OP_READ, 32'h0000_3030, 1'b1);
      add_test("a_kept", OP_READ, 32'h0000_1030, 1'b0);
      add_test("b_evicted", OP_READ, 32'h0000_2038, 1'b1);
      add_test("cold_d", OP_READ, 32'h0000_4054, 1'b1);
      add_test("d_hit", OP_READ, 32'h0000_4050, 1'b0);
      add_test("inval_d", OP_INVAL, 32'h0000_4050, 1'b0);
      add_test("d_after_inval", OP_READ, 32'h0000_4058, 1'b1);
      add_test("d_refilled", OP_READ, 32'h0000_405C, 1'b0);

      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      check_count("reset_idle", "req_ready", 1, int'(req_ready));
      check_count("reset_idle", "rdata_valid", 0, int'(rdata_valid));
      check_count("reset_idle", "mem_req", 0, int'(mem_req));
      check_count("reset_idle", "inv_done", 0, int'(inv_done));
      report_test("reset_idle");

      foreach (tests[i]) begin
         test_errors = 0;
         if (tests[i].op == OP_READ) begin
            run_read(tests[i].name, tests[i].addr, int'(tests[i].miss));
         end else begin
            run_inval(tests[i].name, tests[i].addr);
         end
         report_test(tests[i].name);
         if (timed_out) break;
      end

      // data only, hit or miss depends on earlier traffic
      for (int i = 0; i < NUM_RANDOM && !timed_out; i++) begin
         test_errors = 0;
         run_read($sformatf("random_%0d", i), 32'($urandom_range(0, 255)) << 2, -1);
         report_test($sformatf("random_%0d", i));
      end

      $display("%0d tests run, %0d passed, %0d failed", pass_count + fail_count,
               pass_count, fail_count);
      if (timed_out || fail_count != 0) begin
         $display("SIMULATION FAILED");
      end else begin
         $display("SIMULATION PASSED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
hdl/cache_geom_pkg.sv
hdl/cache_ctrl_pkg.sv
hdl/refill_if.sv
hdl/way_ram.sv
hdl/cache_lookup.sv
hdl/refill_counter.sv
hdl/line_buffer.sv
hdl/icache_fsm.sv
hdl/icache_top.sv
sim/mem_model.sv
sim/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - files:
      - hdl/cache_geom_pkg.sv
      - hdl/cache_ctrl_pkg.sv
      - hdl/refill_if.sv
      - hdl/way_ram.sv
      - hdl/cache_lookup.sv
      - hdl/refill_counter.sv
      - hdl/line_buffer.sv
      - hdl/icache_fsm.sv
      - hdl/icache_top.sv
  - target: simulation
    files:
      - sim/mem_model.sv
      - sim/icache_tb.sv
